// ==== RV_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------

// Width of one data word in bits
`define RV_DATA_WIDTH 32

// Byte address width for a 4 KiB space
`define RV_ADDR_WIDTH 12

// --------------------------------------------------
// Memory and program counter
// --------------------------------------------------

// Depth of the data memory in words
`define RV_MEM_WORDS 1024

// Sequential instruction step
`define RV_PC_STEP 4

`endif

// ==== Types.sv ====
`include "RV_defines.svh"

package Types;

    // --------------------------------------------------
    // Basic datapath types
    // --------------------------------------------------

    typedef logic [`RV_DATA_WIDTH-1:0] Data;       // One data word
    typedef logic [`RV_ADDR_WIDTH-1:0] DataAddr;   // Byte address into data memory
    typedef logic [`RV_ADDR_WIDTH-1:0] InstAddr;   // Instruction address

    // Access size, same coding as the load/store funct3 field
    typedef enum logic [2:0] {
        SizeByte  = 3'b000,     // Signed byte
        SizeHalf  = 3'b001,     // Signed half
        SizeWord  = 3'b010,     // Full word
        SizeByteU = 3'b100,     // Unsigned byte
        SizeHalfU = 3'b101      // Unsigned half
    } AccessSize;

    // Write-back source select
    typedef enum logic [1:0] {
        WbAlu     = 2'b00,      // ALU result
        WbMem     = 2'b01,      // Extended load data
        WbPcPlus4 = 2'b10       // Return address
    } WbSel;

    // --------------------------------------------------
    // Wishbone classic bus
    // --------------------------------------------------

    typedef struct packed {
        logic                       cyc;    // Bus cycle in progress
        logic                       stb;    // Strobe
        logic                       we;     // Write enable
        logic [3:0]                 sel;    // Byte lane selects
        logic [`RV_ADDR_WIDTH-3:0]  adr;    // Word address
        Data                        dat;    // Write data
    } WbRequest;

    typedef struct packed {
        logic ack;                          // Single cycle acknowledge
        Data  dat;                          // Read data, valid with ack
    } WbResponse;

    // Per-instruction input of the memory stage
    typedef struct packed {
        InstAddr   pc;
        Data       result;                  // ALU result, also the access address
        Data       dataB;                   // Store data
        logic      memRead;
        logic      memWrite;
        AccessSize size;
        WbSel      regWrDataSel;
    } MemOp;

endpackage

// ==== StageMEM.sv ====
`include "RV_defines.svh"

module StageMEM
    import Types::*;
(
    input  logic      i_clock,
    input  logic      i_rstN,

    input  logic      i_start,          // One instruction per pulse
    input  MemOp      i_op,
    output logic      o_done,           // Pulses when o_regWrData is valid
    output Data       o_regWrData,

    output WbRequest  o_wbReq,          // Data master on the arbiter
    input  WbResponse i_wbResp);

    typedef enum logic [1:0] {StIdle, StBus, StDone} StageState;

    StageState state;
    MemOp      opReg;                   // Op captured on start
    Data       loadData;                // Extended load word

    DataAddr    addr;
    logic [1:0] offset;
    logic       access;
    logic [3:0] storeSel;
    Data        storeData;
    Data        shifted;
    Data        extended;
    InstAddr    pcPlus4;

    assign addr   = opReg.result[$bits(DataAddr)-1:0];
    assign offset = addr[1:0];          // Byte lane within the word
    assign access = i_op.memRead | i_op.memWrite;

    // --------------------------------------------------
    // Control FSM
    // --------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (!i_rstN) begin
            state <= StIdle;
        end else begin
            case (state)
                StIdle:  if (i_start) state <= access ? StBus : StDone;
                StBus:   if (i_wbResp.ack) state <= StDone;   // Drop cyc right after ack
                StDone:  state <= StIdle;
                default: state <= StIdle;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == StIdle && i_start)
            opReg <= i_op;
        if (state == StBus && i_wbResp.ack)
            loadData <= extended;       // Capture with ack
    end

    assign o_done = (state == StDone);

    // --------------------------------------------------
    // Store lane placement
    // --------------------------------------------------

    always_comb begin
        storeData = opReg.dataB << {offset, 3'b000};
        case (opReg.size)
            SizeByte, SizeByteU: storeSel = 4'b0001 << offset;
            SizeHalf, SizeHalfU: storeSel = 4'b0011 << offset;
            default:             storeSel = 4'b1111;
        endcase
    end

    always_comb begin
        o_wbReq     = '0;
        o_wbReq.cyc = (state == StBus);
        o_wbReq.stb = (state == StBus);
        o_wbReq.we  = opReg.memWrite;
        o_wbReq.sel = opReg.memWrite ? storeSel : 4'b1111;   // Reads take the whole word
        o_wbReq.adr = addr[$bits(DataAddr)-1:2];
        o_wbReq.dat = storeData;
    end

    // --------------------------------------------------
    // Load extension and write-back select
    // --------------------------------------------------

    always_comb begin
        shifted = i_wbResp.dat >> {offset, 3'b000};   // Wanted lane down to bit 0
        case (opReg.size)
            SizeByte:  extended = {{(`RV_DATA_WIDTH-8){shifted[7]}}, shifted[7:0]};
            SizeHalf:  extended = {{(`RV_DATA_WIDTH-16){shifted[15]}}, shifted[15:0]};
            SizeByteU: extended = {{(`RV_DATA_WIDTH-8){1'b0}}, shifted[7:0]};
            SizeHalfU: extended = {{(`RV_DATA_WIDTH-16){1'b0}}, shifted[15:0]};
            default:   extended = shifted;
        endcase
    end

    assign pcPlus4 = opReg.pc + InstAddr'(`RV_PC_STEP);

    always_comb begin
        case (opReg.regWrDataSel)
            WbMem:     o_regWrData = loadData;
            WbPcPlus4: o_regWrData = {{(`RV_DATA_WIDTH-$bits(InstAddr)){1'b0}}, pcPlus4};
            default:   o_regWrData = opReg.result;              // WbAlu
        endcase
    end

endmodule

// ==== FetchPort.sv ====
module FetchPort
    import Types::*;
(
    input  logic      i_clock,
    input  logic      i_rstN,

    input  logic      i_fetchReq,       // Start one fetch
    input  InstAddr   i_fetchAddr,
    output Data       o_inst,
    output logic      o_instValid,      // One cycle pulse with o_inst

    output WbRequest  o_wbReq,          // Fetch master on the arbiter
    input  WbResponse i_wbResp);

    logic    busy;                      // Read cycle open on the bus
    InstAddr fetchAddr;                 // Latched request address
    Data     instWord;

    // --------------------------------------------------
    // Request tracking
    // --------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (!i_rstN) begin
            busy        <= 1'b0;
            o_instValid <= 1'b0;
        end else begin
            o_instValid <= busy & i_wbResp.ack;     // Pulse the cycle after ack
            if (!busy && i_fetchReq)
                busy <= 1'b1;
            else if (busy && i_wbResp.ack)
                busy <= 1'b0;                       // Release cyc after ack
        end
    end

    always_ff @(posedge i_clock) begin
        if (!busy && i_fetchReq)
            fetchAddr <= i_fetchAddr;
        if (busy && i_wbResp.ack)
            instWord <= i_wbResp.dat;               // Word arrives with ack
    end

    assign o_inst = instWord;

    // --------------------------------------------------
    // Bus request
    // --------------------------------------------------

    always_comb begin
        o_wbReq     = '0;
        o_wbReq.cyc = busy;
        o_wbReq.stb = busy;
        o_wbReq.we  = 1'b0;                         // Fetch only reads
        o_wbReq.sel = 4'b1111;
        o_wbReq.adr = fetchAddr[$bits(InstAddr)-1:2];
    end

endmodule

// ==== BusArbiter.sv ====
module BusArbiter
    import Types::*;
(
    input  logic      i_clock,
    input  logic      i_rstN,

    // Master 0 has priority
    input  WbRequest  i_req0,
    output WbResponse o_resp0,

    // Master 1
    input  WbRequest  i_req1,
    output WbResponse o_resp1,

    // Shared slave
    output WbRequest  o_slaveReq,
    input  WbResponse i_slaveResp);

    typedef enum logic [1:0] {
        GrantIdle,                      // No owner
        GrantM0,                        // Master 0 owns the bus
        GrantM1                         // Master 1 owns the bus
    } GrantState;

    GrantState grant;

    // --------------------------------------------------
    // Grant register
    // --------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (!i_rstN) begin
            grant <= GrantIdle;
        end else begin
            case (grant)
                GrantIdle: begin
                    if (i_req0.cyc)
                        grant <= GrantM0;               // Lowest index wins
                    else if (i_req1.cyc)
                        grant <= GrantM1;
                end
                GrantM0: begin
                    if (!i_req0.cyc)
                        grant <= GrantIdle;             // Held for the whole bus cycle
                end
                GrantM1: begin
                    if (!i_req1.cyc)
                        grant <= GrantIdle;
                end
                default: grant <= GrantIdle;
            endcase
        end
    end

    // --------------------------------------------------
    // Request and response steering
    // --------------------------------------------------

    always_comb begin
        o_slaveReq = '0;                // Slave sees no cycle while idle
        o_resp0    = '0;                // Ungranted master sees no ack
        o_resp1    = '0;
        case (grant)
            GrantM0: begin
                o_slaveReq = i_req0;
                o_resp0    = i_slaveResp;
            end
            GrantM1: begin
                o_slaveReq = i_req1;
                o_resp1    = i_slaveResp;
            end
            default: begin
                o_slaveReq = '0;
            end
        endcase
    end

endmodule

// ==== DataMemory.sv ====
`include "RV_defines.svh"

module DataMemory
    import Types::*;
(
    input  logic      i_clock,
    input  logic      i_rstN,

    input  WbRequest  i_wbReq,          // From the arbiter
    output WbResponse o_wbResp);

    localparam int Lanes = `RV_DATA_WIDTH / 8;     // Bytes per word

    Data  memWords [`RV_MEM_WORDS];     // Word organized storage
    Data  rdWord;                       // Registered read data
    logic ack;
    logic access;

    // New access only while ack is low, so ack lasts one cycle
    assign access = i_wbReq.cyc & i_wbReq.stb & ~ack;

    // --------------------------------------------------
    // Acknowledge
    // --------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (!i_rstN)
            ack <= 1'b0;
        else
            ack <= access;
    end

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (access) begin
            if (i_wbReq.we) begin
                for (int lane = 0; lane < Lanes; lane++) begin
                    if (i_wbReq.sel[lane])
                        memWords[i_wbReq.adr][8*lane +: 8] <= i_wbReq.dat[8*lane +: 8];
                end
            end
            rdWord <= memWords[i_wbReq.adr];        // Old word on a write cycle
        end
    end

    always_comb begin
        o_wbResp     = '0;
        o_wbResp.ack = ack;
        o_wbResp.dat = rdWord;                      // Read data valid with ack
    end

endmodule

// ==== MemorySystem.sv ====
module MemorySystem
    import Types::*;
(
    input  logic    i_clock,
    input  logic    i_rstN,

    // Memory stage side
    input  logic    i_start,
    input  MemOp    i_op,
    output logic    o_done,
    output Data     o_regWrData,

    // Instruction fetch side
    input  logic    i_fetchReq,
    input  InstAddr i_fetchAddr,
    output Data     o_inst,
    output logic    o_instValid);

    WbRequest  dataReq;                 // Stage to arbiter port 0
    WbResponse dataResp;
    WbRequest  fetchBusReq;             // Fetch to arbiter port 1
    WbResponse fetchBusResp;
    WbRequest  slaveReq;                // Arbiter to memory
    WbResponse slaveResp;

    // --------------------------------------------------
    // Masters
    // --------------------------------------------------

    StageMEM stageMem (
        .i_clock     (i_clock),
        .i_rstN      (i_rstN),
        .i_start     (i_start),
        .i_op        (i_op),
        .o_done      (o_done),
        .o_regWrData (o_regWrData),
        .o_wbReq     (dataReq),
        .i_wbResp    (dataResp));

    FetchPort fetchPort (
        .i_clock     (i_clock),
        .i_rstN      (i_rstN),
        .i_fetchReq  (i_fetchReq),
        .i_fetchAddr (i_fetchAddr),
        .o_inst      (o_inst),
        .o_instValid (o_instValid),
        .o_wbReq     (fetchBusReq),
        .i_wbResp    (fetchBusResp));

    // --------------------------------------------------
    // Arbiter and shared memory
    // --------------------------------------------------

    BusArbiter busArbiter (
        .i_clock     (i_clock),
        .i_rstN      (i_rstN),
        .i_req0      (dataReq),         // Data access first
        .o_resp0     (dataResp),
        .i_req1      (fetchBusReq),
        .o_resp1     (fetchBusResp),
        .o_slaveReq  (slaveReq),
        .i_slaveResp (slaveResp));

    DataMemory dataMemory (
        .i_clock     (i_clock),
        .i_rstN      (i_rstN),
        .i_wbReq     (slaveReq),
        .o_wbResp    (slaveResp));

endmodule

// ==== MemorySystemTb.sv ====
module MemorySystemTb
    import Types::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {OrderNone, OrderDataFirst, OrderFetchFirst, OrderTogether}
        CompletionOrder;

    typedef struct packed {
        MemOp    op;                    // Stage input for this row
        logic    fetch;                 // Fetch issued in the same cycle
        InstAddr fetchAddr;
    } TableRow;

    logic    i_clock;
    logic    i_rstN;
    logic    i_start;
    MemOp    i_op;
    logic    o_done;
    Data     o_regWrData;
    logic    i_fetchReq;
    InstAddr i_fetchAddr;
    Data     o_inst;
    logic    o_instValid;

    TableRow    rows [$];               // Stimulus table
    logic [7:0] refMem [4096];          // Byte-wide reference memory
    int         seed = 32'h947c_6a23;
    int         cycleCount = 0;
    int         cycleLimit = 0;
    int         dataErrors = 0;
    int         orderErrors = 0;
    int         latencyErrors = 0;

    MemorySystem dut0 (.*);

    always #5 i_clock = ~i_clock;       // 10 ns period

    // --------------------------------------------------
    // Timeout watchdog
    // --------------------------------------------------

    always @(posedge i_clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------

    task automatic checkData(input string what, input Data got, input Data exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            dataErrors++;
        end
    endtask

    task automatic checkOrder(input string what, input CompletionOrder got,
                              input CompletionOrder exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %s expected %s", $time, what,
                     got.name(), exp.name());
            orderErrors++;
        end
    endtask

    task automatic checkLatency(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s got %0d cycles expected %0d", $time, what,
                     got, exp);
            latencyErrors++;
        end
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    // Performs the op on refMem and returns the expected write-back value
    function automatic Data applyModel(input MemOp op);
        int      base;
        int      nBytes;
        Data     loaded;
        InstAddr pcNext;
        base = int'(op.result[11:0]);
        case (op.size)
            SizeByte, SizeByteU: nBytes = 1;
            SizeHalf, SizeHalfU: nBytes = 2;
            default:             nBytes = 4;
        endcase
        if (op.memWrite)
            for (int i = 0; i < nBytes; i++)
                refMem[base + i] = op.dataB[8*i +: 8];  // Low bytes of dataB go out
        loaded = '0;
        for (int i = 0; i < nBytes; i++)
            loaded[8*i +: 8] = refMem[base + i];        // Little endian
        if (op.size == SizeByte)
            loaded = {{24{loaded[7]}}, loaded[7:0]};
        if (op.size == SizeHalf)
            loaded = {{16{loaded[15]}}, loaded[15:0]};
        pcNext = op.pc + 12'd4;                         // Wraps in the 4 KiB space
        case (op.regWrDataSel)
            WbMem:     return loaded;
            WbPcPlus4: return {20'h00000, pcNext};
            default:   return op.result;
        endcase
    endfunction

    function automatic Data readWord(input InstAddr addr);
        int a;
        a = int'({addr[11:2], 2'b00});
        return {refMem[a + 3], refMem[a + 2], refMem[a + 1], refMem[a]};
    endfunction

    function automatic Data randWord();
        return $random(seed);
    endfunction

    // --------------------------------------------------
    // Stimulus table
    // --------------------------------------------------

    task automatic addRow(input InstAddr pc, input Data result, input Data dataB,
                          input logic rd, input logic wr, input AccessSize size,
                          input WbSel sel, input logic fetch, input InstAddr fAddr);
        TableRow row;
        row.op        = '{pc, result, dataB, rd, wr, size, sel};
        row.fetch     = fetch;
        row.fetchAddr = fAddr;
        rows.push_back(row);
    endtask

    task automatic buildTable();
        addRow(12'h000, 32'h100, randWord(), 1'b0, 1'b1, SizeWord, WbAlu, 1'b0, 12'h0);  // SW
        addRow(12'h004, 32'h100, 32'h0, 1'b1, 1'b0, SizeWord, WbMem, 1'b0, 12'h0);       // LW
        addRow(12'h008, 32'h104, 32'h80f17f82, 1'b0, 1'b1, SizeWord, WbAlu, 1'b0, 12'h0);
        for (int off = 0; off < 4; off++) begin                     // Every byte lane
            addRow(12'h00c, 32'h104 + off, 32'h0, 1'b1, 1'b0, SizeByte, WbMem, 1'b0, 12'h0);
            addRow(12'h010, 32'h104 + off, 32'h0, 1'b1, 1'b0, SizeByteU, WbMem, 1'b0, 12'h0);
        end
        for (int off = 0; off < 4; off += 2) begin                  // Both half lanes
            addRow(12'h014, 32'h104 + off, 32'h0, 1'b1, 1'b0, SizeHalf, WbMem, 1'b0, 12'h0);
            addRow(12'h018, 32'h104 + off, 32'h0, 1'b1, 1'b0, SizeHalfU, WbMem, 1'b0, 12'h0);
        end
        addRow(12'h01c, 32'h108, 32'h11223344, 1'b0, 1'b1, SizeWord, WbAlu, 1'b0, 12'h0);
        addRow(12'h020, 32'h109, randWord(), 1'b0, 1'b1, SizeByte, WbAlu, 1'b0, 12'h0);  // SB
        addRow(12'h024, 32'h10a, randWord(), 1'b0, 1'b1, SizeHalf, WbAlu, 1'b0, 12'h0);  // SH
        addRow(12'h028, 32'h108, 32'h0, 1'b1, 1'b0, SizeWord, WbMem, 1'b0, 12'h0);       // Merged
        addRow(12'h02c, 32'hdeadbeef, 32'h0, 1'b0, 1'b0, SizeWord, WbAlu, 1'b0, 12'h0);
        addRow(12'h7f8, 32'h12345678, 32'h0, 1'b0, 1'b0, SizeWord, WbPcPlus4, 1'b0, 12'h0);
        addRow(12'hffc, 32'h0, 32'h0, 1'b0, 1'b0, SizeWord, WbPcPlus4, 1'b0, 12'h0);     // Wrap
        addRow(12'h030, 32'h5a5a, 32'h0, 1'b0, 1'b0, SizeWord, WbAlu, 1'b1, 12'h100);    // Fetch
        addRow(12'h034, 32'ha5a5, 32'h0, 1'b0, 1'b0, SizeWord, WbAlu, 1'b1, 12'h108);
        addRow(12'h038, 32'h10c, randWord(), 1'b0, 1'b1, SizeWord, WbAlu, 1'b1, 12'h104);
        addRow(12'h03c, 32'h10c, 32'h0, 1'b1, 1'b0, SizeWord, WbMem, 1'b1, 12'h10c);
        addRow(12'h040, 32'h10e, randWord(), 1'b0, 1'b1, SizeHalf, WbAlu, 1'b1, 12'h10c);
    endtask

    // --------------------------------------------------
    // Row execution
    // --------------------------------------------------

    task automatic runRow(input TableRow row, input int idx);
        Data            expReg;
        Data            expInst;
        bit             doneSeen;
        bit             instSeen;
        bit             newDone;
        bit             newInst;
        int             waitCycles;
        CompletionOrder order;
        expReg  = applyModel(row.op);           // Data access lands first
        expInst = readWord(row.fetchAddr);
        @(posedge i_clock);
        i_start     <= 1'b1;
        i_op        <= row.op;
        i_fetchReq  <= row.fetch;
        i_fetchAddr <= row.fetchAddr;
        @(posedge i_clock);                     // DUT samples the pulse here
        i_start    <= 1'b0;
        i_fetchReq <= 1'b0;
        doneSeen   = 1'b0;
        instSeen   = !row.fetch;
        order      = OrderNone;
        waitCycles = 0;
        while (!(doneSeen && instSeen)) begin
            @(negedge i_clock);                 // Outputs settled mid cycle
            waitCycles++;
            newDone = o_done && !doneSeen;
            newInst = row.fetch && o_instValid && !instSeen;
            if (order == OrderNone) begin
                if (newDone && newInst)
                    order = OrderTogether;
                else if (newDone)
                    order = OrderDataFirst;
                else if (newInst)
                    order = OrderFetchFirst;
            end
            if (newDone) begin
                doneSeen = 1'b1;
                checkData($sformatf("row %0d regWrData", idx), o_regWrData, expReg);
                if (!row.fetch)                 // Uncontended timing only
                    checkLatency($sformatf("row %0d done latency", idx), waitCycles,
                                 (row.op.memRead || row.op.memWrite) ? 4 : 1);
            end
            if (newInst) begin
                instSeen = 1'b1;
                checkData($sformatf("row %0d inst", idx), o_inst, expInst);
            end
        end
        if (row.fetch)
            checkOrder($sformatf("row %0d completion order", idx), order, OrderDataFirst);
    endtask

    initial begin
        i_clock     = 1'b0;
        i_rstN      = 1'b0;
        i_start     = 1'b0;
        i_op        = '0;
        i_fetchReq  = 1'b0;
        i_fetchAddr = '0;
        buildTable();
        cycleLimit = 40 * rows.size() + 20;
        repeat (2) @(posedge i_clock);
        i_rstN <= 1'b1;
        foreach (rows[i])
            runRow(rows[i], i);
        @(posedge i_clock);
        $display("Errors: data=%0d order=%0d latency=%0d", dataErrors, orderErrors,
                 latencyErrors);
        if (dataErrors + orderErrors + latencyErrors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
Types.sv
StageMEM.sv
FetchPort.sv
BusArbiter.sv
DataMemory.sv
MemorySystem.sv
MemorySystemTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module MemorySystemTb -o simv

output=$(./obj_dir/simv)
echo "$output"

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
else
    exit 1
fi
